/* hw/race_defines.svh */
`ifndef RACE_DEFINES_SVH
`define RACE_DEFINES_SVH

// largest velocity magnitude, either direction
`define RACE_VMAX 255

// laps needed to win
`define RACE_LAPS 2

// cycles a key level has to hold before it counts
`define RACE_DEBOUNCE 4

// track memory address width, one word per tile
`define RACE_TRACK_AW 8

`endif

/* hw/race_pkg.sv */
`default_nettype none

package race_pkg;

	// game flow
	typedef enum logic [1:0] {
		S_IDLE,
		S_RACE,
		S_FINISH
	} race_state_t;

	// signed speed, clamped well inside the range
	typedef logic signed [9:0] velocity_t;

	// position on the loop, top byte is the tile index
	typedef logic [15:0] position_t;

	// track word, bit 0 set means grass
	typedef logic [15:0] tile_t;

	typedef logic [1:0] lap_t;

	// active low, g in bit 6 down to a in bit 0
	typedef logic [6:0] seg7_t;

endpackage

`default_nettype wire

/* hw/key_debounce.sv */
`default_nettype none

`include "race_defines.svh"

module key_debounce #(
	parameter int DEBOUNCE_CYCLES = `RACE_DEBOUNCE
) (
	input  logic i_clk,
	input  logic i_reset,
	input  logic i_key_n,
	output logic o_press
);

	localparam int CW = $clog2(DEBOUNCE_CYCLES + 1);

	// sampled key and the level accepted so far
	logic          key_q;
	logic          level;
	logic [CW-1:0] count;

	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			key_q   <= 1'b1;
			level   <= 1'b1;
			count   <= '0;
			o_press <= 1'b0;
		end else begin
			key_q   <= i_key_n;
			o_press <= 1'b0;
			if (key_q == level) begin
				// glitch over, start again
				count <= '0;
			end else if (count == CW'(DEBOUNCE_CYCLES - 1)) begin
				level   <= key_q;
				count   <= '0;
				// only a falling key is a press
				o_press <= ~key_q;
			end else begin
				count <= count + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

/* hw/race_fsm.sv */
`default_nettype none

`include "race_defines.svh"

module race_fsm (
	input  logic                  i_clk,
	input  logic                  i_reset,
	input  logic                  i_start,
	input  logic                  i_restart,
	input  race_pkg::lap_t        i_car1_lap,
	input  race_pkg::lap_t        i_car2_lap,
	output race_pkg::race_state_t o_state,
	output logic                  o_run,
	output logic                  o_clear,
	output logic [1:0]            o_winner
);
	import race_pkg::*;

	logic car1_done;
	logic car2_done;

	assign car1_done = (i_car1_lap >= lap_t'(`RACE_LAPS));
	assign car2_done = (i_car2_lap >= lap_t'(`RACE_LAPS));

	assign o_run = (o_state == S_RACE);

	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			o_state  <= S_IDLE;
			o_clear  <= 1'b0;
			o_winner <= 2'd0;
		end else begin
			o_clear <= 1'b0;
			case (o_state)
				S_IDLE: begin
					if (i_start) begin
						o_state <= S_RACE;
						o_clear <= 1'b1;
					end
				end
				S_RACE: begin
					if (i_restart) begin
						o_state  <= S_IDLE;
						o_winner <= 2'd0;
					end else if (!o_clear && (car1_done || car2_done)) begin
						// laps from the last race are still there while clear is high
						o_state  <= S_FINISH;
						o_winner <= {car2_done, car1_done};
					end
				end
				S_FINISH: begin
					if (i_restart) begin
						o_state  <= S_IDLE;
						o_winner <= 2'd0;
					end
				end
				default: begin
					o_state <= S_IDLE;
				end
			endcase
		end
	end

	// clear marks the first race cycle and nothing else
	assert property (@(posedge i_clk) disable iff (i_reset)
		o_clear |-> ($past(o_state) == S_IDLE) && (o_state == S_RACE));

endmodule

`default_nettype wire

/* hw/car_dynamics.sv */
`default_nettype none

`include "race_defines.svh"

module car_dynamics (
	input  logic                      i_clk,
	input  logic                      i_reset,
	input  logic                      i_clear,
	input  logic                      i_run,
	input  logic                      i_frame_tick,
	input  logic signed [2:0]         i_acc,
	output logic                      o_req,
	output logic [`RACE_TRACK_AW-1:0] o_addr,
	input  logic                      i_rvalid,
	input  race_pkg::tile_t           i_rdata,
	output race_pkg::velocity_t       o_velocity,
	output race_pkg::position_t       o_position,
	output race_pkg::lap_t            o_lap
);
	import race_pkg::*;

	logic signed [10:0] vel_sum;
	velocity_t          vel_next;
	position_t          pos_next;
	logic               on_grass;
	logic               lap_wrap;

	assign on_grass = i_rdata[0];

	always_comb begin
		// one bit of headroom for the clamp
		vel_sum = {o_velocity[9], o_velocity} + {{8{i_acc[2]}}, i_acc};
		if (on_grass) begin
			// grass drags toward standstill, pedal ignored
			if (o_velocity > 0) begin
				vel_next = o_velocity - 10'sd1;
			end else if (o_velocity < 0) begin
				vel_next = o_velocity + 10'sd1;
			end else begin
				vel_next = '0;
			end
		end else if (vel_sum > `RACE_VMAX) begin
			vel_next = velocity_t'(`RACE_VMAX);
		end else if (vel_sum < -`RACE_VMAX) begin
			vel_next = velocity_t'(-`RACE_VMAX);
		end else begin
			vel_next = vel_sum[9:0];
		end
	end

	// position wraps mod 2^16
	assign pos_next = o_position + position_t'({{6{vel_next[9]}}, vel_next});

	// forward wrap past the line counts a lap, backward does not
	assign lap_wrap = (vel_next > 0) && (pos_next < o_position);

	always_ff @(posedge i_clk) begin
		if (i_reset || i_clear) begin
			o_req      <= 1'b0;
			o_velocity <= '0;
			o_position <= '0;
			o_lap      <= '0;
		end else if (o_req) begin
			if (i_rvalid) begin
				o_req      <= 1'b0;
				o_velocity <= vel_next;
				o_position <= pos_next;
				if (lap_wrap && (o_lap != 2'd3)) begin
					o_lap <= o_lap + 1'b1;
				end
			end
		end else if (i_run && i_frame_tick) begin
			o_req <= 1'b1;
		end
	end

	// tile under the car, held with the request
	always_ff @(posedge i_clk) begin
		if (!o_req && i_frame_tick) begin
			o_addr <= o_position[15 -: `RACE_TRACK_AW];
		end
	end

	// arbiter answers only a read that is still open
	assert property (@(posedge i_clk) disable iff (i_reset)
		i_rvalid |-> o_req);

endmodule

`default_nettype wire

/* hw/track_arbiter.sv */
`default_nettype none

`include "race_defines.svh"

module track_arbiter (
	input  logic                      i_clk,
	input  logic                      i_reset,
	input  logic                      i_req1,
	input  logic [`RACE_TRACK_AW-1:0] i_addr1,
	input  logic                      i_req2,
	input  logic [`RACE_TRACK_AW-1:0] i_addr2,
	output logic                      o_rvalid1,
	output logic                      o_rvalid2,
	output race_pkg::tile_t           o_rdata,
	input  logic                      i_load_we,
	input  logic [`RACE_TRACK_AW-1:0] i_load_addr,
	input  race_pkg::tile_t           i_load_data,
	output logic                      o_mem_en,
	output logic                      o_mem_we,
	output logic [`RACE_TRACK_AW-1:0] o_mem_addr,
	output race_pkg::tile_t           o_mem_wdata,
	input  race_pkg::tile_t           i_mem_rdata
);

	// set when car 2 got the last grant
	logic       last_two;
	// read in flight, bit 0 car 1, bit 1 car 2
	logic [1:0] grant_q;
	logic       elig1;
	logic       elig2;
	logic       gnt1;
	logic       gnt2;

	// request still up in its valid cycle, don't serve it twice
	assign elig1 = i_req1 && !grant_q[0];
	assign elig2 = i_req2 && !grant_q[1];

	always_comb begin
		gnt1 = 1'b0;
		gnt2 = 1'b0;
		// loads win outright, readers just wait
		if (!i_load_we) begin
			if (elig1 && elig2) begin
				gnt1 = last_two;
				gnt2 = !last_two;
			end else begin
				gnt1 = elig1;
				gnt2 = elig2;
			end
		end
	end

	assign o_mem_en    = i_load_we || gnt1 || gnt2;
	assign o_mem_we    = i_load_we;
	assign o_mem_addr  = i_load_we ? i_load_addr : (gnt1 ? i_addr1 : i_addr2);
	assign o_mem_wdata = i_load_data;

	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			last_two <= 1'b1;
			grant_q  <= 2'b00;
		end else begin
			grant_q <= {gnt2, gnt1};
			if (gnt1 || gnt2) begin
				last_two <= gnt2;
			end
		end
	end

	// memory data lands with the valid of the car that asked
	assign o_rvalid1 = grant_q[0];
	assign o_rvalid2 = grant_q[1];
	assign o_rdata   = i_mem_rdata;

	assert property (@(posedge i_clk) disable iff (i_reset)
		!(o_rvalid1 && o_rvalid2));

	// a car keeps its request and address open until its data is back
	assert property (@(posedge i_clk) disable iff (i_reset)
		o_rvalid1 |-> i_req1 && $stable(i_addr1));

	assert property (@(posedge i_clk) disable iff (i_reset)
		o_rvalid2 |-> i_req2 && $stable(i_addr2));

endmodule

`default_nettype wire

/* hw/track_sram.sv */
`default_nettype none

`include "race_defines.svh"

module track_sram (
	input  logic                      i_clk,
	input  logic                      i_en,
	input  logic                      i_we,
	input  logic [`RACE_TRACK_AW-1:0] i_addr,
	input  race_pkg::tile_t           i_wdata,
	output race_pkg::tile_t           o_rdata
);
	import race_pkg::*;

	localparam int DEPTH = 1 << `RACE_TRACK_AW;

	tile_t mem [DEPTH];

	// power-up image, all road
	initial begin
		for (int i = 0; i < DEPTH; i++) begin
			mem[i] = '0;
		end
	end

	always @(posedge i_clk) begin
		if (i_en && i_we) begin
			mem[i_addr] <= i_wdata;
		end
	end

	// registered read, one cycle
	always_ff @(posedge i_clk) begin
		if (i_en && !i_we) begin
			o_rdata <= mem[i_addr];
		end
	end

endmodule

`default_nettype wire

/* hw/speed_display.sv */
`default_nettype none

module speed_display (
	input  race_pkg::velocity_t i_velocity,
	output race_pkg::seg7_t     o_sign,
	output race_pkg::seg7_t     o_hundred,
	output race_pkg::seg7_t     o_ten,
	output race_pkg::seg7_t     o_one
);
	import race_pkg::*;

	localparam seg7_t SEG_BLANK = 7'b1111111;
	// only segment g lit
	localparam seg7_t SEG_MINUS = 7'b0111111;

	logic [9:0] mag;
	logic [3:0] hun;
	logic [3:0] ten;
	logic [3:0] one;

	function automatic seg7_t digit_seg(input logic [3:0] d);
		case (d)
			4'd0:    digit_seg = 7'b1000000;
			4'd1:    digit_seg = 7'b1111001;
			4'd2:    digit_seg = 7'b0100100;
			4'd3:    digit_seg = 7'b0110000;
			4'd4:    digit_seg = 7'b0011001;
			4'd5:    digit_seg = 7'b0010010;
			4'd6:    digit_seg = 7'b0000010;
			4'd7:    digit_seg = 7'b1111000;
			4'd8:    digit_seg = 7'b0000000;
			4'd9:    digit_seg = 7'b0010000;
			default: digit_seg = SEG_BLANK;
		endcase
	endfunction

	// two's complement magnitude
	assign mag = i_velocity[9] ? (~i_velocity + 10'd1) : i_velocity;

	assign hun = 4'(mag / 10'd100);
	assign ten = 4'((mag / 10'd10) % 10'd10);
	assign one = 4'(mag % 10'd10);

	assign o_sign = i_velocity[9] ? SEG_MINUS : SEG_BLANK;

	// leading zeros dark, ones always on
	assign o_hundred = (hun == 4'd0) ? SEG_BLANK : digit_seg(hun);
	assign o_ten     = (hun == 4'd0 && ten == 4'd0) ? SEG_BLANK : digit_seg(ten);
	assign o_one     = digit_seg(one);

endmodule

`default_nettype wire

/* hw/race_core.sv */
`default_nettype none

`include "race_defines.svh"

module race_core (
	input  logic                      i_clk,
	input  logic                      i_reset,
	input  logic                      i_frame_tick,
	input  logic                      i_key_start_n,
	input  logic                      i_key_restart_n,
	input  logic signed [2:0]         i_car1_acc,
	input  logic signed [2:0]         i_car2_acc,
	input  logic                      i_load_we,
	input  logic [`RACE_TRACK_AW-1:0] i_load_addr,
	input  race_pkg::tile_t           i_load_data,
	output race_pkg::race_state_t     o_state,
	output logic [1:0]                o_winner,
	output race_pkg::velocity_t       o_car1_velocity,
	output race_pkg::velocity_t       o_car2_velocity,
	output race_pkg::position_t       o_car1_position,
	output race_pkg::position_t       o_car2_position,
	output race_pkg::lap_t            o_car1_lap,
	output race_pkg::lap_t            o_car2_lap,
	output race_pkg::seg7_t           o_hex7,
	output race_pkg::seg7_t           o_hex6,
	output race_pkg::seg7_t           o_hex5,
	output race_pkg::seg7_t           o_hex4,
	output race_pkg::seg7_t           o_hex3,
	output race_pkg::seg7_t           o_hex2,
	output race_pkg::seg7_t           o_hex1,
	output race_pkg::seg7_t           o_hex0
);
	import race_pkg::*;

	logic                      start_press;
	logic                      restart_press;
	logic                      run;
	logic                      clear;
	logic                      car1_req;
	logic                      car2_req;
	logic [`RACE_TRACK_AW-1:0] car1_addr;
	logic [`RACE_TRACK_AW-1:0] car2_addr;
	logic                      car1_rvalid;
	logic                      car2_rvalid;
	tile_t                     rdata;
	logic                      mem_en;
	logic                      mem_we;
	logic [`RACE_TRACK_AW-1:0] mem_addr;
	tile_t                     mem_wdata;
	tile_t                     mem_rdata;

	key_debounce deb_start (
		.i_clk   (i_clk),
		.i_reset (i_reset),
		.i_key_n (i_key_start_n),
		.o_press (start_press)
	);

	key_debounce deb_restart (
		.i_clk   (i_clk),
		.i_reset (i_reset),
		.i_key_n (i_key_restart_n),
		.o_press (restart_press)
	);

	race_fsm u_fsm (
		.i_clk      (i_clk),
		.i_reset    (i_reset),
		.i_start    (start_press),
		.i_restart  (restart_press),
		.i_car1_lap (o_car1_lap),
		.i_car2_lap (o_car2_lap),
		.o_state    (o_state),
		.o_run      (run),
		.o_clear    (clear),
		.o_winner   (o_winner)
	);

	car_dynamics u_car1 (
		.i_clk        (i_clk),
		.i_reset      (i_reset),
		.i_clear      (clear),
		.i_run        (run),
		.i_frame_tick (i_frame_tick),
		.i_acc        (i_car1_acc),
		.o_req        (car1_req),
		.o_addr       (car1_addr),
		.i_rvalid     (car1_rvalid),
		.i_rdata      (rdata),
		.o_velocity   (o_car1_velocity),
		.o_position   (o_car1_position),
		.o_lap        (o_car1_lap)
	);

	car_dynamics u_car2 (
		.i_clk        (i_clk),
		.i_reset      (i_reset),
		.i_clear      (clear),
		.i_run        (run),
		.i_frame_tick (i_frame_tick),
		.i_acc        (i_car2_acc),
		.o_req        (car2_req),
		.o_addr       (car2_addr),
		.i_rvalid     (car2_rvalid),
		.i_rdata      (rdata),
		.o_velocity   (o_car2_velocity),
		.o_position   (o_car2_position),
		.o_lap        (o_car2_lap)
	);

	// both cars and the load port share one memory
	track_arbiter u_arbiter (
		.i_clk       (i_clk),
		.i_reset     (i_reset),
		.i_req1      (car1_req),
		.i_addr1     (car1_addr),
		.i_req2      (car2_req),
		.i_addr2     (car2_addr),
		.o_rvalid1   (car1_rvalid),
		.o_rvalid2   (car2_rvalid),
		.o_rdata     (rdata),
		.i_load_we   (i_load_we),
		.i_load_addr (i_load_addr),
		.i_load_data (i_load_data),
		.o_mem_en    (mem_en),
		.o_mem_we    (mem_we),
		.o_mem_addr  (mem_addr),
		.o_mem_wdata (mem_wdata),
		.i_mem_rdata (mem_rdata)
	);

	track_sram u_track (
		.i_clk   (i_clk),
		.i_en    (mem_en),
		.i_we    (mem_we),
		.i_addr  (mem_addr),
		.i_wdata (mem_wdata),
		.o_rdata (mem_rdata)
	);

	// car 1 on the left four digits
	speed_display car1_value (
		.i_velocity (o_car1_velocity),
		.o_sign     (o_hex7),
		.o_hundred  (o_hex6),
		.o_ten      (o_hex5),
		.o_one      (o_hex4)
	);

	speed_display car2_value (
		.i_velocity (o_car2_velocity),
		.o_sign     (o_hex3),
		.o_hundred  (o_hex2),
		.o_ten      (o_hex1),
		.o_one      (o_hex0)
	);

endmodule

`default_nettype wire

/* tb/race_core_tb.sv */
`default_nettype none

`include "race_defines.svh"

module race_core_tb;
	import race_pkg::*;

	localparam int TICK_CYCLES      = 20;
	localparam int IDLE_TICKS       = 4;
	localparam int ROAD_TICKS       = 200;
	localparam int GRASS_TICKS      = 150;
	localparam int FINISH_MAX_TICKS = 800;
	// keys, track loads and checks around the ticks of one test
	localparam int TEST_MARGIN      = 800;
	localparam int WATCHDOG_CYCLES  =
		(IDLE_TICKS + ROAD_TICKS + GRASS_TICKS + FINISH_MAX_TICKS) * TICK_CYCLES
		+ 5 * TEST_MARGIN;
	localparam int KEY_HOLD         = `RACE_DEBOUNCE + 4;

	logic                      i_clk;
	logic                      i_reset;
	logic                      i_frame_tick;
	logic                      i_key_start_n;
	logic                      i_key_restart_n;
	logic signed [2:0]         i_car1_acc;
	logic signed [2:0]         i_car2_acc;
	logic                      i_load_we;
	logic [`RACE_TRACK_AW-1:0] i_load_addr;
	tile_t                     i_load_data;
	race_state_t               o_state;
	logic [1:0]                o_winner;
	velocity_t                 o_car1_velocity;
	velocity_t                 o_car2_velocity;
	position_t                 o_car1_position;
	position_t                 o_car2_position;
	lap_t                      o_car1_lap;
	lap_t                      o_car2_lap;
	seg7_t                     o_hex7;
	seg7_t                     o_hex6;
	seg7_t                     o_hex5;
	seg7_t                     o_hex4;
	seg7_t                     o_hex3;
	seg7_t                     o_hex2;
	seg7_t                     o_hex1;
	seg7_t                     o_hex0;

	// reference model of the game
	int          m_vel [2];
	int          m_pos [2];
	int          m_lap [2];
	race_state_t m_state;
	logic [1:0]  m_winner;
	tile_t       m_track [256];
	int          clamp_hits;
	int          grass_moves;
	int          error_count;

	race_core i_race_core (
		.i_clk           (i_clk),
		.i_reset         (i_reset),
		.i_frame_tick    (i_frame_tick),
		.i_key_start_n   (i_key_start_n),
		.i_key_restart_n (i_key_restart_n),
		.i_car1_acc      (i_car1_acc),
		.i_car2_acc      (i_car2_acc),
		.i_load_we       (i_load_we),
		.i_load_addr     (i_load_addr),
		.i_load_data     (i_load_data),
		.o_state         (o_state),
		.o_winner        (o_winner),
		.o_car1_velocity (o_car1_velocity),
		.o_car2_velocity (o_car2_velocity),
		.o_car1_position (o_car1_position),
		.o_car2_position (o_car2_position),
		.o_car1_lap      (o_car1_lap),
		.o_car2_lap      (o_car2_lap),
		.o_hex7          (o_hex7),
		.o_hex6          (o_hex6),
		.o_hex5          (o_hex5),
		.o_hex4          (o_hex4),
		.o_hex3          (o_hex3),
		.o_hex2          (o_hex2),
		.o_hex1          (o_hex1),
		.o_hex0          (o_hex0)
	);

	initial begin
		i_clk = 1'b0;
		forever #4 i_clk = ~i_clk;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge i_clk);
		$display("timeout, DUT did not finish");
		$display("Verification failed");
		$fatal(1, "watchdog expired");
	end

	task automatic stop_run();
		error_count++;
		$display("Verification failed");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_state(input string name, input race_state_t got, input race_state_t exp);
		if (got !== exp) begin
			$display("[FAIL] %s: got %h, expected %h", name, got, exp);
			stop_run();
		end
	endtask

	task automatic check_winner(input string name, input logic [1:0] got, input logic [1:0] exp);
		if (got !== exp) begin
			$display("[FAIL] %s: got %h, expected %h", name, got, exp);
			stop_run();
		end
	endtask

	task automatic check_velocity(input string name, input velocity_t got, input velocity_t exp);
		if (got !== exp) begin
			$display("[FAIL] %s: got %h, expected %h", name, got, exp);
			stop_run();
		end
	endtask

	task automatic check_position(input string name, input position_t got, input position_t exp);
		if (got !== exp) begin
			$display("[FAIL] %s: got %h, expected %h", name, got, exp);
			stop_run();
		end
	endtask

	task automatic check_lap(input string name, input lap_t got, input lap_t exp);
		if (got !== exp) begin
			$display("[FAIL] %s: got %h, expected %h", name, got, exp);
			stop_run();
		end
	endtask

	task automatic check_seg(input string name, input seg7_t got, input seg7_t exp);
		if (got !== exp) begin
			$display("[FAIL] %s: got %h, expected %h", name, got, exp);
			stop_run();
		end
	endtask

	task automatic fail_plain(input string why);
		$display("%s", why);
		stop_run();
	endtask

	// lit segments gfedcba, inverted for the active-low display
	function automatic seg7_t digit_pattern(input int d);
		logic [6:0] lit;
		case (d)
			0:       lit = 7'h3f;
			1:       lit = 7'h06;
			2:       lit = 7'h5b;
			3:       lit = 7'h4f;
			4:       lit = 7'h66;
			5:       lit = 7'h6d;
			6:       lit = 7'h7d;
			7:       lit = 7'h07;
			8:       lit = 7'h7f;
			default: lit = 7'h6f;
		endcase
		return ~lit;
	endfunction

	// top_digit is the hex index of the sign digit
	task automatic check_display(input int vel, input seg7_t sign, input seg7_t hun,
		input seg7_t ten, input seg7_t one, input int top_digit);
		int mag;
		int hd;
		int td;
		seg7_t blank;
		blank = 7'h7f;
		mag = (vel < 0) ? -vel : vel;
		hd = mag / 100;
		td = (mag / 10) % 10;
		check_seg($sformatf("o_hex%0d", top_digit), sign, (vel < 0) ? 7'h3f : blank);
		check_seg($sformatf("o_hex%0d", top_digit - 1), hun,
			(hd == 0) ? blank : digit_pattern(hd));
		check_seg($sformatf("o_hex%0d", top_digit - 2), ten,
			(hd == 0 && td == 0) ? blank : digit_pattern(td));
		check_seg($sformatf("o_hex%0d", top_digit - 3), one, digit_pattern(mag % 10));
	endtask

	task automatic check_all();
		check_state("o_state", o_state, m_state);
		check_winner("o_winner", o_winner, m_winner);
		check_velocity("o_car1_velocity", o_car1_velocity, velocity_t'(m_vel[0]));
		check_velocity("o_car2_velocity", o_car2_velocity, velocity_t'(m_vel[1]));
		check_position("o_car1_position", o_car1_position, position_t'(m_pos[0]));
		check_position("o_car2_position", o_car2_position, position_t'(m_pos[1]));
		check_lap("o_car1_lap", o_car1_lap, lap_t'(m_lap[0]));
		check_lap("o_car2_lap", o_car2_lap, lap_t'(m_lap[1]));
		check_display(m_vel[0], o_hex7, o_hex6, o_hex5, o_hex4, 7);
		check_display(m_vel[1], o_hex3, o_hex2, o_hex1, o_hex0, 3);
	endtask

	function automatic int rand_range(input int lo, input int hi);
		return lo + int'($urandom % 32'(hi - lo + 1));
	endfunction

	// one frame of a car, from the game rules
	task automatic model_car(input int c, input int acc);
		int tile_idx;
		int v;
		int p;
		tile_idx = m_pos[c] / 256;
		v = m_vel[c];
		if (m_track[tile_idx][0]) begin
			if (v > 0) begin
				v = v - 1;
			end else if (v < 0) begin
				v = v + 1;
			end
			if (m_vel[c] != 0) begin
				grass_moves++;
			end
		end else begin
			v = v + acc;
			if (v > `RACE_VMAX) begin
				v = `RACE_VMAX;
				clamp_hits++;
			end else if (v < -`RACE_VMAX) begin
				v = -`RACE_VMAX;
				clamp_hits++;
			end
		end
		p = m_pos[c] + v;
		if (p >= 65536) begin
			p = p - 65536;
			if (m_lap[c] < 3) begin
				m_lap[c]++;
			end
		end else if (p < 0) begin
			p = p + 65536;
		end
		m_vel[c] = v;
		m_pos[c] = p;
	endtask

	task automatic run_tick(input int acc1, input int acc2);
		@(negedge i_clk);
		i_car1_acc = 3'(acc1);
		i_car2_acc = 3'(acc2);
		i_frame_tick = 1'b1;
		@(negedge i_clk);
		i_frame_tick = 1'b0;
		// cars are done within 8 cycles of the tick
		repeat (7) @(negedge i_clk);
		if (m_state == S_RACE) begin
			// both cars ask every frame, so car 1 keeps the first read slot
			// and its finish is seen a cycle before car 2's
			model_car(0, acc1);
			if (m_lap[0] >= `RACE_LAPS) begin
				m_state = S_FINISH;
				m_winner = 2'd1;
			end
			model_car(1, acc2);
			if (m_state == S_RACE && m_lap[1] >= `RACE_LAPS) begin
				m_state = S_FINISH;
				m_winner = 2'd2;
			end
		end
		check_all();
		repeat (TICK_CYCLES - 9) @(negedge i_clk);
	endtask

	task automatic press_key(input bit restart_key, input int low_cycles);
		@(negedge i_clk);
		if (restart_key) begin
			i_key_restart_n = 1'b0;
		end else begin
			i_key_start_n = 1'b0;
		end
		repeat (low_cycles) @(negedge i_clk);
		i_key_start_n = 1'b1;
		i_key_restart_n = 1'b1;
		// let the release settle before the next press
		repeat (KEY_HOLD) @(negedge i_clk);
	endtask

	task automatic wait_for_state(input race_state_t exp);
		int n;
		n = 0;
		while (o_state !== exp && n < 16) begin
			@(negedge i_clk);
			n++;
		end
		if (o_state !== exp) begin
			fail_plain($sformatf("game state did not reach %s after the key press", exp.name()));
		end
	endtask

	task automatic start_race();
		press_key(1'b0, KEY_HOLD);
		wait_for_state(S_RACE);
		for (int c = 0; c < 2; c++) begin
			m_vel[c] = 0;
			m_pos[c] = 0;
			m_lap[c] = 0;
		end
		m_state = S_RACE;
		m_winner = 2'd0;
		check_all();
	endtask

	task automatic restart_game();
		press_key(1'b1, KEY_HOLD);
		wait_for_state(S_IDLE);
		m_state = S_IDLE;
		m_winner = 2'd0;
		check_all();
	endtask

	// grass on tiles whose index has bit 5 set, upper bits carry the address
	task automatic load_track(input bit with_grass);
		for (int a = 0; a < 256; a++) begin
			@(negedge i_clk);
			i_load_we = 1'b1;
			i_load_addr = 8'(a);
			i_load_data = {8'(a), 7'h00, with_grass & a[5]};
			m_track[a] = i_load_data;
		end
		@(negedge i_clk);
		i_load_we = 1'b0;
	endtask

	task automatic test_reset_state();
		check_all();
		for (int i = 0; i < IDLE_TICKS; i++) begin
			run_tick(rand_range(-4, 3), rand_range(-4, 3));
		end
	endtask

	task automatic test_debounce();
		press_key(1'b0, `RACE_DEBOUNCE - 1);
		repeat (8) @(negedge i_clk);
		check_state("o_state", o_state, S_IDLE);
		start_race();
	endtask

	task automatic test_road();
		clamp_hits = 0;
		for (int i = 0; i < ROAD_TICKS; i++) begin
			if (i < 150) begin
				run_tick(rand_range(1, 3), rand_range(-4, -1));
			end else begin
				run_tick(rand_range(-4, 3), rand_range(-4, 3));
			end
		end
		if (clamp_hits == 0) begin
			fail_plain("road test never reached the speed limit");
		end
	endtask

	task automatic test_grass();
		restart_game();
		load_track(1'b1);
		start_race();
		grass_moves = 0;
		for (int i = 0; i < GRASS_TICKS; i++) begin
			run_tick(rand_range(0, 3), rand_range(-4, 0));
		end
		if (grass_moves == 0) begin
			fail_plain("grass test never drove a moving car over grass");
		end
	endtask

	task automatic test_finish();
		int n;
		restart_game();
		load_track(1'b0);
		start_race();
		n = 0;
		while (m_state == S_RACE && n < FINISH_MAX_TICKS) begin
			run_tick(rand_range(1, 3), rand_range(1, 3));
			n++;
		end
		if (m_state != S_FINISH) begin
			fail_plain("no car finished the race in the allowed ticks");
		end
		check_state("o_state", o_state, S_FINISH);
		restart_game();
		check_winner("o_winner", o_winner, 2'd0);
	endtask

	initial begin
		void'($urandom(32'hac00_7c6f));
		i_reset = 1'b1;
		i_frame_tick = 1'b0;
		i_key_start_n = 1'b1;
		i_key_restart_n = 1'b1;
		i_car1_acc = 3'd0;
		i_car2_acc = 3'd0;
		i_load_we = 1'b0;
		i_load_addr = '0;
		i_load_data = '0;
		error_count = 0;
		clamp_hits = 0;
		grass_moves = 0;
		for (int c = 0; c < 2; c++) begin
			m_vel[c] = 0;
			m_pos[c] = 0;
			m_lap[c] = 0;
		end
		for (int a = 0; a < 256; a++) begin
			m_track[a] = '0;
		end
		m_state = S_IDLE;
		m_winner = 2'd0;
		repeat (10) @(negedge i_clk);
		i_reset = 1'b0;
		@(negedge i_clk);

		test_reset_state();
		test_debounce();
		test_road();
		test_grass();
		test_finish();

		if (error_count == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* race_core.f */
+incdir+hw
hw/race_pkg.sv
hw/key_debounce.sv
hw/race_fsm.sv
hw/car_dynamics.sv
hw/track_arbiter.sv
hw/track_sram.sv
hw/speed_display.sv
hw/race_core.sv
tb/race_core_tb.sv

/* Makefile */
TOP = race_core_tb

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): race_core.f $(wildcard hw/*.sv hw/*.svh tb/*.sv)
	verilator --binary --timing --assert -j 0 -Wno-fatal --top-module $(TOP) -f race_core.f

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "Verification passed"

lint:
	verilator --lint-only --timing -Wall --top-module race_core -f race_core.f

clean:
	rm -rf obj_dir
